// File: hw/isaPkg.sv
package isaPkg;

	// one fetched instruction as held in the instruction register
	typedef logic [31:0] instrWord;

	// position of the class field inside the instruction
	localparam int classLsb = 25;
	localparam int classMsb = 27;

	// data processing uses this bit as S, branches use it as L
	localparam int sBitPos = 20;

	// raw class field as it sits in bits 27..25
	typedef logic [classMsb-classLsb:0] classCode;

	// instruction classes the control unit tells apart
	// codes 4 and 6 have no class of their own and fold into other
	typedef enum logic [2:0] {
		dpShifter   = 3'd0,
		dpImmediate = 3'd1,
		lsImmediate = 3'd2,
		lsRegister  = 3'd3,
		branch      = 3'd5,
		other       = 3'd7
	} instrClass;

endpackage

// File: hw/ctrlPkg.sv
package ctrlPkg;

	// sequencer states, numbered as in the original state chart
	typedef enum logic [3:0] {
		reset        = 4'd0,
		fetchAddr    = 4'd1,
		fetchInc     = 4'd2,
		fetchWait    = 4'd3,
		decode       = 4'd4,
		dpImmExec    = 4'd5,
		dpImmWrite   = 4'd6,
		dpShiftExec  = 4'd7,
		branchTarget = 4'd8,
		branchAdd    = 4'd9,
		branchLink   = 4'd10,
		branchCommit = 4'd11
	} ctrlState;

	// datapath select fields
	typedef logic [1:0] muxSel2;
	typedef logic [2:0] muxSel3;
	typedef logic [5:0] shiftSel;
	typedef logic [4:0] aluOpcode;
	typedef logic [2:0] shiftType;

	// memory access size, 2 selects a full word
	typedef logic [1:0] dataType;

	// what the decoder tells the sequencer and the word generator
	typedef struct packed {
		isaPkg::instrClass cls;
		logic              setFlags;
		logic              link;
	} decodedInstr;

	// everything the datapath needs for one cycle
	typedef struct packed {
		logic     ldRf;
		logic     ldIr;
		logic     ldMar;
		logic     ldFr;
		logic     clr;
		logic     rw;
		logic     mov;
		logic     md;
		logic     mh;
		logic     aluEn;
		dataType  typeData;
		muxSel2   maSel;
		muxSel2   mbSel;
		muxSel2   mfSel;
		muxSel2   miSel;
		muxSel2   mjSel;
		muxSel3   mcSel;
		shiftType shType;
		shiftSel  shSel;
		aluOpcode aluOp;
	} controlWord;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
(
	input  isaPkg::instrWord    ir,
	output ctrlPkg::decodedInstr dec
);

	isaPkg::classCode code;

	assign code = ir[isaPkg::classMsb:isaPkg::classLsb];

	always_comb
	begin
		dec = '0;

		case (code)
			3'd0:
			begin
				dec.cls = isaPkg::dpShifter;
			end
			3'd1:
			begin
				dec.cls = isaPkg::dpImmediate;
			end
			3'd2:
			begin
				dec.cls = isaPkg::lsImmediate;
			end
			3'd3:
			begin
				dec.cls = isaPkg::lsRegister;
			end
			3'd5:
			begin
				dec.cls = isaPkg::branch;
			end
			// 4, 6 and 7 are not handled by this unit
			default:
			begin
				dec.cls = isaPkg::other;
			end
		endcase

		// same bit, read as S or as L depending on the class
		dec.setFlags = ir[isaPkg::sBitPos];
		dec.link     = ir[isaPkg::sBitPos];
	end

endmodule

// File: hw/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer
(
	input  logic                 CLK,
	input  logic                 arstN,
	input  ctrlPkg::decodedInstr dec,
	input  logic                 cond,
	input  logic                 moc,
	output ctrlPkg::ctrlState    state
);

	ctrlPkg::ctrlState nextState;

	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= ctrlPkg::reset;
		end
		else
		begin
			state <= nextState;
		end
	end

	// pick the first execute state of the decoded instruction
	function automatic ctrlPkg::ctrlState dispatch(ctrlPkg::decodedInstr d);
		ctrlPkg::ctrlState target;

		case (d.cls)
			isaPkg::dpImmediate:
			begin
				target = ctrlPkg::dpImmExec;
			end
			isaPkg::dpShifter:
			begin
				target = ctrlPkg::dpShiftExec;
			end
			isaPkg::branch:
			begin
				// link first saves the return address, then the plain branch
				target = d.link ? ctrlPkg::branchLink : ctrlPkg::branchTarget;
			end
			// loads, stores and the rest go straight back to fetch
			default:
			begin
				target = ctrlPkg::fetchAddr;
			end
		endcase

		return target;
	endfunction

	always_comb
	begin
		case (state)
			ctrlPkg::reset:
			begin
				nextState = ctrlPkg::fetchAddr;
			end
			ctrlPkg::fetchAddr:
			begin
				nextState = ctrlPkg::fetchInc;
			end
			ctrlPkg::fetchInc:
			begin
				nextState = ctrlPkg::fetchWait;
			end
			ctrlPkg::fetchWait:
			begin
				// hold until memory reports the word is there
				nextState = moc ? ctrlPkg::decode : ctrlPkg::fetchWait;
			end
			ctrlPkg::decode:
			begin
				if (!cond)
				begin
					nextState = ctrlPkg::fetchAddr;
				end
				else
				begin
					nextState = dispatch(dec);
				end
			end
			ctrlPkg::dpImmExec:
			begin
				nextState = ctrlPkg::dpImmWrite;
			end
			ctrlPkg::branchLink:
			begin
				nextState = ctrlPkg::branchTarget;
			end
			ctrlPkg::branchTarget:
			begin
				nextState = ctrlPkg::branchAdd;
			end
			ctrlPkg::branchAdd:
			begin
				nextState = ctrlPkg::branchCommit;
			end
			// dpImmWrite, dpShiftExec, branchCommit end the instruction
			default:
			begin
				nextState = ctrlPkg::fetchAddr;
			end
		endcase
	end

endmodule

// File: hw/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen
(
	input  ctrlPkg::ctrlState    state,
	input  ctrlPkg::decodedInstr dec,
	output ctrlPkg::controlWord  ctrl
);

	always_comb
	begin
		ctrl = '0;

		case (state)
			ctrlPkg::reset:
			begin
				ctrl.clr = 1'b1;
			end

			// pc to mar through the alu pass
			ctrlPkg::fetchAddr:
			begin
				ctrl.ldMar = 1'b1;
				ctrl.maSel = 2'd2;
				ctrl.md    = 1'b1;
				ctrl.aluOp = 5'd16;
			end

			// start the word read and bump pc
			ctrlPkg::fetchInc:
			begin
				ctrl.ldRf     = 1'b1;
				ctrl.rw       = 1'b1;
				ctrl.mov      = 1'b1;
				ctrl.typeData = 2'd2;
				ctrl.maSel    = 2'd2;
				ctrl.mcSel    = 3'd3;
				ctrl.md       = 1'b1;
				ctrl.aluOp    = 5'd17;
			end

			// keep the read going and catch the word in ir
			ctrlPkg::fetchWait:
			begin
				ctrl.ldIr     = 1'b1;
				ctrl.rw       = 1'b1;
				ctrl.mov      = 1'b1;
				ctrl.typeData = 2'd2;
			end

			ctrlPkg::decode:
			begin
				ctrl = '0;
			end

			ctrlPkg::dpImmExec:
			begin
				ctrl.ldRf   = 1'b1;
				ctrl.mbSel  = 2'd1;
				ctrl.mcSel  = 3'd4;
				ctrl.mfSel  = 2'd3;
				ctrl.md     = 1'b1;
				ctrl.aluEn  = 1'b1;
				ctrl.shType = 3'd1;
				ctrl.aluOp  = 5'd19;
			end

			// flags only load when the S bit asks for it
			ctrlPkg::dpImmWrite:
			begin
				ctrl.ldRf   = 1'b1;
				ctrl.miSel  = 2'd2;
				ctrl.mjSel  = 2'd1;
				ctrl.shType = 3'd4;
				ctrl.ldFr   = dec.setFlags;
			end

			ctrlPkg::dpShiftExec:
			begin
				ctrl.ldRf  = 1'b1;
				ctrl.mbSel = 2'd1;
				ctrl.mh    = 1'b1;
				ctrl.miSel = 2'd1;
				ctrl.ldFr  = dec.setFlags;
			end

			ctrlPkg::branchTarget:
			begin
				ctrl.ldRf   = 1'b1;
				ctrl.ldFr   = 1'b1;
				ctrl.mbSel  = 2'd1;
				ctrl.mcSel  = 3'd4;
				ctrl.md     = 1'b1;
				ctrl.mfSel  = 2'd3;
				ctrl.miSel  = 2'd2;
				ctrl.mjSel  = 2'd2;
				ctrl.aluEn  = 1'b1;
				ctrl.shType = 3'd4;
				ctrl.aluOp  = 5'd19;
			end

			// offset add into pc, issued twice
			ctrlPkg::branchAdd,
			ctrlPkg::branchCommit:
			begin
				ctrl.ldRf   = 1'b1;
				ctrl.maSel  = 2'd2;
				ctrl.mbSel  = 2'd1;
				ctrl.mcSel  = 3'd3;
				ctrl.md     = 1'b1;
				ctrl.miSel  = 2'd2;
				ctrl.mjSel  = 2'd1;
				ctrl.shType = 3'd5;
				ctrl.shSel  = 6'd4;
				ctrl.aluOp  = 5'd4;
			end

			// copy pc into the link register
			ctrlPkg::branchLink:
			begin
				ctrl.ldRf  = 1'b1;
				ctrl.maSel = 2'd3;
				ctrl.mcSel = 3'd2;
				ctrl.md    = 1'b1;
				ctrl.mjSel = 2'd1;
				ctrl.shSel = 6'd4;
				ctrl.aluOp = 5'd16;
			end

			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: hw/armControlTop.sv
`timescale 1ns/1ps

module armControlTop
(
	input  logic                CLK,
	input  logic                arstN,
	input  isaPkg::instrWord    ir,
	input  logic                cond,
	input  logic                moc,
	output ctrlPkg::controlWord ctrl
);

	ctrlPkg::decodedInstr dec;
	ctrlPkg::ctrlState    state;

	instrDecoder decoder
	(
		.ir  (ir),
		.dec (dec)
	);

	controlSequencer sequencer
	(
		.CLK   (CLK),
		.arstN (arstN),
		.dec   (dec),
		.cond  (cond),
		.moc   (moc),
		.state (state)
	);

	controlWordGen wordGen
	(
		.state (state),
		.dec   (dec),
		.ctrl  (ctrl)
	);

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic CLK,
	output logic arstN
);

	// 8 ns period
	initial
	begin
		CLK = 1'b0;
	end

	always #4 CLK = ~CLK;

	// hold reset through the first 10 rising edges, release on a falling edge
	initial
	begin
		arstN = 1'b0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;
	end

endmodule

// File: test/armControlTb.sv
`timescale 1ns/1ps

module armControlTb;

	logic                CLK;
	logic                arstN;
	isaPkg::instrWord    ir;
	logic                cond;
	logic                moc;
	ctrlPkg::controlWord ctrl;

	ctrlPkg::ctrlState mState = ctrlPkg::reset;
	logic [31:0]       rngState = 32'd76;

	clockGen clocks
	(
		.CLK   (CLK),
		.arstN (arstN)
	);

	armControlTop UUT
	(
		.CLK   (CLK),
		.arstN (arstN),
		.ir    (ir),
		.cond  (cond),
		.moc   (moc),
		.ctrl  (ctrl)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;

		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic drawRandom(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	task automatic stopRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("FAIL time %0t %s got %h expected %h", $time, name, got, expected);
			stopRun("control word differs from the reference model");
		end
	endtask

	// reference sequencer, written from the state chart
	function automatic ctrlPkg::ctrlState modelNext(input ctrlPkg::ctrlState s,
		input logic [31:0] instr, input logic c, input logic m);
		logic [2:0]        code;
		ctrlPkg::ctrlState n;

		code = instr[27:25];
		n = ctrlPkg::fetchAddr;
		case (s)
			ctrlPkg::fetchAddr:    n = ctrlPkg::fetchInc;
			ctrlPkg::fetchInc:     n = ctrlPkg::fetchWait;
			ctrlPkg::fetchWait:    n = m ? ctrlPkg::decode : ctrlPkg::fetchWait;
			ctrlPkg::dpImmExec:    n = ctrlPkg::dpImmWrite;
			ctrlPkg::branchLink:   n = ctrlPkg::branchTarget;
			ctrlPkg::branchTarget: n = ctrlPkg::branchAdd;
			ctrlPkg::branchAdd:    n = ctrlPkg::branchCommit;
			ctrlPkg::decode:
			begin
				if (c && code == 3'd1)
					n = ctrlPkg::dpImmExec;
				else if (c && code == 3'd0)
					n = ctrlPkg::dpShiftExec;
				else if (c && code == 3'd5)
					n = instr[20] ? ctrlPkg::branchLink : ctrlPkg::branchTarget;
			end
			default:               n = ctrlPkg::fetchAddr;
		endcase
		return n;
	endfunction

	// reference word table
	function automatic ctrlPkg::controlWord expectedWord(input ctrlPkg::ctrlState s,
		input logic sBit);
		ctrlPkg::controlWord w;

		w = '0;
		case (s)
			ctrlPkg::reset: w.clr = 1'b1;
			ctrlPkg::fetchAddr:
			begin
				w.ldMar = 1'b1;
				w.maSel = 2'd2;
				w.md    = 1'b1;
				w.aluOp = 5'd16;
			end
			ctrlPkg::fetchInc:
			begin
				{w.ldRf, w.rw, w.mov, w.md} = 4'b1111;
				w.typeData = 2'd2;
				w.maSel    = 2'd2;
				w.mcSel    = 3'd3;
				w.aluOp    = 5'd17;
			end
			ctrlPkg::fetchWait:
			begin
				{w.ldIr, w.rw, w.mov} = 3'b111;
				w.typeData = 2'd2;
			end
			ctrlPkg::dpImmExec:
			begin
				{w.ldRf, w.md, w.aluEn} = 3'b111;
				w.mbSel  = 2'd1;
				w.mcSel  = 3'd4;
				w.mfSel  = 2'd3;
				w.shType = 3'd1;
				w.aluOp  = 5'd19;
			end
			ctrlPkg::dpImmWrite:
			begin
				w.ldRf   = 1'b1;
				w.ldFr   = sBit;
				w.miSel  = 2'd2;
				w.mjSel  = 2'd1;
				w.shType = 3'd4;
			end
			ctrlPkg::dpShiftExec:
			begin
				{w.ldRf, w.mh} = 2'b11;
				w.ldFr  = sBit;
				w.mbSel = 2'd1;
				w.miSel = 2'd1;
			end
			ctrlPkg::branchTarget:
			begin
				{w.ldRf, w.ldFr, w.md, w.aluEn} = 4'b1111;
				w.mbSel  = 2'd1;
				w.mcSel  = 3'd4;
				w.mfSel  = 2'd3;
				w.miSel  = 2'd2;
				w.mjSel  = 2'd2;
				w.shType = 3'd4;
				w.aluOp  = 5'd19;
			end
			ctrlPkg::branchAdd, ctrlPkg::branchCommit:
			begin
				{w.ldRf, w.md} = 2'b11;
				w.maSel  = 2'd2;
				w.mbSel  = 2'd1;
				w.mcSel  = 3'd3;
				w.miSel  = 2'd2;
				w.mjSel  = 2'd1;
				w.shType = 3'd5;
				w.shSel  = 6'd4;
				w.aluOp  = 5'd4;
			end
			ctrlPkg::branchLink:
			begin
				{w.ldRf, w.md} = 2'b11;
				w.maSel = 2'd3;
				w.mcSel = 3'd2;
				w.mjSel = 2'd1;
				w.shSel = 6'd4;
				w.aluOp = 5'd16;
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	always @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
			mState <= ctrlPkg::reset;
		else
			mState <= modelNext(mState, ir, cond, moc);
	end

	// inputs move 1 ns after the rising edge, compare once they have settled
	always @(posedge CLK)
	begin
		#3;
		checkValue("ctrl", 64'(ctrl), 64'(expectedWord(mState, ir[isaPkg::sBitPos])));
	end

	task automatic nextCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic runInstruction();
		logic [31:0] r;
		logic [31:0] s;
		int          delay;
		int          cycles;

		drawRandom(r);
		drawRandom(s);
		ir = {s[31:28], r[2:0], s[24:0]};
		cond = (r[9:8] != 2'd0);
		delay = int'(r[23:16] % 8'd6);
		moc = 1'b0;

		// ldIr is only raised while waiting for memory
		cycles = 0;
		while (ctrl.ldIr !== 1'b1)
		begin
			nextCycle();
			cycles++;
			if (cycles > 4)
				stopRun("fetch did not reach the memory wait within 4 cycles");
		end

		// memory stays busy for a random number of cycles
		for (int i = 0; i < delay; i++)
			nextCycle();
		moc = 1'b1;

		// decode is the only state with an all-zero word
		cycles = 0;
		while (ctrl !== '0)
		begin
			nextCycle();
			cycles++;
			if (cycles > 2)
				stopRun("no decode after memory reported completion");
		end
		moc = 1'b0;

		cycles = 0;
		do
		begin
			nextCycle();
			cycles++;
			if (cycles > 8)
				stopRun("instruction did not return to fetch within 8 cycles");
		end
		while (ctrl.ldMar !== 1'b1);
	endtask

	initial
	begin
		int cycles;

		ir = '0;
		cond = 1'b0;
		moc = 1'b0;

		cycles = 0;
		while (arstN !== 1'b1)
		begin
			nextCycle();
			cycles++;
			if (cycles > 20)
				stopRun("reset was never released");
		end

		// ldMar marks the address phase of a fetch
		cycles = 0;
		while (ctrl.ldMar !== 1'b1)
		begin
			nextCycle();
			cycles++;
			if (cycles > 4)
				stopRun("no fetch after reset release");
		end

		for (int n = 0; n < 400; n++)
			runInstruction();

		nextCycle();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: build.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/controlSequencer.sv
hw/controlWordGen.sv
hw/armControlTop.sv
test/clockGen.sv
test/armControlTb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := armControlTb
FILELIST := build.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
